/* chan_stream_if.sv */
// channel readout stream, valid/ready handshake with packet end and channel tag
`timescale 1ns/1ps

interface chan_stream_if;

    logic                  tvalid;  // source has a word
    logic                  tready;  // sink takes it this cycle
    logic                  tlast;   // final word of the packet
    wfd_pkg::chan_data_t   tdata;
    wfd_pkg::chan_id_t     tid;     // which channel the word came from

    // producer side
    modport source (
        output tvalid, tlast, tdata, tid,
        input  tready
    );

    // consumer side
    modport sink (
        input  tvalid, tlast, tdata, tid,
        output tready
    );

endinterface

/* event_builder.sv */
// event builder, frames each fill for the daq link as header, tagged payload and trailer
`timescale 1ns/1ps
`include "wfd_config.svh"

module event_builder import wfd_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      fill_valid,     // fill number fifo head
    input  fill_num_t fill_num,
    output logic      fill_ready,     // pop
    chan_stream_if.sink merged,       // merged channel packets
    output logic      daq_out_valid,
    output daq_word_t daq_out,
    input  logic      daq_out_ready,  // daq fifo has room
    output logic      busy            // holds off new triggers
);

    localparam int LC_W = $clog2(`WFD_NUM_CHAN + 1);

    builder_state_t  state;
    fill_num_t       fill_q;     // fill being framed
    logic [31:0]     word_cnt;   // payload words so far
    logic [LC_W-1:0] last_cnt;   // packets finished so far
    logic            pay_xfer;
    logic            out_xfer;

    assign fill_ready = (state == ST_IDLE);
    assign busy       = (state != ST_IDLE);  // pop through trailer write

    // payload moves only when the daq side can take it
    assign merged.tready = (state == ST_PAYLOAD) && daq_out_ready;
    assign pay_xfer      = merged.tvalid && merged.tready;
    assign out_xfer      = daq_out_valid && daq_out_ready;

    // output word formed from state
    always_comb begin
        daq_out_valid = 1'b0;
        daq_out       = '0;
        case (state)
            ST_HEADER: begin
                daq_out_valid  = 1'b1;
                daq_out.header = 1'b1;
                daq_out.data   = {`WFD_HEADER_MARK, fill_q, 32'd0};
            end
            ST_PAYLOAD: begin
                daq_out_valid = merged.tvalid;
                daq_out.data  = {8'(merged.tid), fill_q, merged.tdata};  // tag with channel
            end
            ST_TRAILER: begin
                daq_out_valid   = 1'b1;
                daq_out.trailer = 1'b1;
                daq_out.data    = {`WFD_TRAILER_MARK, fill_q, word_cnt};
            end
            default: begin
                daq_out_valid = 1'b0;  // idle, nothing out
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            last_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (fill_valid) begin
                        state    <= ST_HEADER;
                        last_cnt <= '0;
                    end
                end
                ST_HEADER: begin
                    if (out_xfer)
                        state <= ST_PAYLOAD;
                end
                ST_PAYLOAD: begin
                    if (pay_xfer && merged.tlast) begin
                        last_cnt <= last_cnt + 1'b1;
                        if (last_cnt == LC_W'(`WFD_NUM_CHAN - 1))
                            state <= ST_TRAILER;  // every channel in
                    end
                end
                ST_TRAILER: begin
                    if (out_xfer)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // fill number and word count, restarted on each pop
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && fill_valid) begin
            fill_q   <= fill_num;
            word_cnt <= '0;
        end else if (pay_xfer) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // a word is either the event start or the event end
    assert property (@(posedge clk) disable iff (rst)
        daq_out_valid |-> !(daq_out.header && daq_out.trailer));

endmodule

/* rx_switch.sv */
// round robin packet arbiter merging channel streams into one tagged stream
`timescale 1ns/1ps
`include "wfd_config.svh"

module rx_switch import wfd_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    chan_stream_if.sink   chan_in [`WFD_NUM_CHAN],
    chan_stream_if.source merged
);

    localparam int N = `WFD_NUM_CHAN;

    logic [N-1:0] in_valid;
    logic [N-1:0] in_last;
    chan_data_t   in_data [N];
    chan_id_t     in_id   [N];
    chan_id_t     grant;      // input currently forwarded
    chan_id_t     grant_nxt;  // round robin successor
    logic         pkt_open;   // between first word and tlast
    logic         xfer;

    // flatten the interface array, only the granted input sees ready
    for (genvar i = 0; i < N; i++) begin : g_port
        assign in_valid[i]      = chan_in[i].tvalid;
        assign in_last[i]       = chan_in[i].tlast;
        assign in_data[i]       = chan_in[i].tdata;
        assign in_id[i]         = chan_in[i].tid;
        assign chan_in[i].tready = merged.tready && (grant == chan_id_t'(i));
    end

    // straight pass-through of the granted input
    assign merged.tvalid = in_valid[grant];
    assign merged.tlast  = in_last[grant];
    assign merged.tdata  = in_data[grant];
    assign merged.tid    = in_id[grant];

    assign xfer      = merged.tvalid && merged.tready;
    assign grant_nxt = (grant == chan_id_t'(N - 1)) ? '0 : grant + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant    <= '0;
            pkt_open <= 1'b0;
        end else begin
            if (xfer)
                pkt_open <= !merged.tlast;  // single word packet never opens
            if (xfer && merged.tlast)
                grant <= grant_nxt;         // packet done, next in turn
            else if (!pkt_open && !in_valid[grant])
                grant <= grant_nxt;         // nothing here, keep looking
        end
    end

    // a packet stays on one input until its tlast goes through
    assert property (@(posedge clk) disable iff (rst)
        (pkt_open && !(xfer && merged.tlast)) |=> $stable(grant));

endmodule

/* sync_fifo.sv */
// single clock fifo with valid/ready on both sides, payload type set by parameter
`timescale 1ns/1ps

module sync_fifo import wfd_pkg::*; #(
    parameter type payload_t = fill_num_t,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t   mem [DEPTH];  // storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;  // words held
    logic       wr_en;
    logic       rd_en;
    logic       full;

    assign full      = (count == CNT_W'(DEPTH));
    assign in_ready  = !full;
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];  // head word sits until popped
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or both at once
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= in_data;
    end

    // an accepted write never lands on a word still waiting to be read
    assert property (@(posedge clk) disable iff (rst)
        (wr_en && (count != '0)) |-> (wr_ptr != rd_ptr));

endmodule

/* tb_wfd_top.sv */
// testbench for the wfd acquisition path, random channel packets checked against a model
`timescale 1ns/1ps
`include "wfd_config.svh"

module tb_wfd_top import wfd_pkg::*; ();

    localparam int NCH          = `WFD_NUM_CHAN;
    localparam int MAX_WORDS    = 8;    // longest channel packet
    localparam int TOTAL_FILLS  = 32;   // 1 + 1 + 20 + 10 fills over the tests
    localparam int STALL_FACTOR = 16;   // covers valid gaps and daq back-pressure
    localparam int PERIOD_NS    = 8;
    localparam int WATCHDOG_NS  = TOTAL_FILLS * (MAX_WORDS * NCH + 4) * STALL_FACTOR * PERIOD_NS;

    // one expected payload word, kept per channel
    typedef struct packed {
        logic       last;
        fill_num_t  fill;
        chan_data_t data;
    } exp_word_t;

    logic                  clk125    = 1'b0;
    logic                  rst       = 1'b1;
    logic                  trigger   = 1'b0;
    logic [NCH-1:0]        acq_trigs;
    logic [NCH-1:0]        chan_done = '0;
    logic [NCH-1:0]        ch_valid  = '0;
    logic [NCH-1:0]        ch_last   = '0;
    chan_data_t            ch_data [NCH] = '{default: '0};
    logic [NCH-1:0]        ch_ready;
    logic                  c0_tready;
    logic                  c1_tready;
    logic                  daq_valid;
    logic                  daq_header;
    logic                  daq_trailer;
    logic [`WFD_DAQ_W-1:0] daq_data;
    logic                  daq_ready = 1'b0;

    exp_word_t  exp_c0 [$];              // model of channel 0 words still due
    exp_word_t  exp_c1 [$];
    fill_num_t  exp_fill [$];            // fills started, header not yet seen
    chan_data_t pkt [NCH][MAX_WORDS];    // packet each channel model is sending
    int         pkt_len [NCH] = '{default: 0};
    int         pkt_pos [NCH] = '{default: 0};
    fill_num_t  model_fill    = '0;      // counts accepted triggers
    logic       acq_prev      = 1'b0;
    int         stall_pct     = 0;       // percent of cycles with daq_ready low
    int         acq_pulses    = 0;
    int         events_done   = 0;
    int         fills_started = 0;
    int         err_cnt       = 0;
    int         n_tests       = 0;
    int         n_bad         = 0;
    logic       in_event      = 1'b0;    // sink between header and trailer
    logic       pkt_open      = 1'b0;
    logic [7:0] open_chan     = '0;
    fill_num_t  cur_fill      = '0;
    fill_num_t  hdr_next      = fill_num_t'(1);
    int         cur_cnt       = 0;

    assign ch_ready = {c1_tready, c0_tready};

    wfd_top wfd_top_inst (
        .clk125(clk125), .rst(rst), .trigger(trigger),
        .acq_trigs(acq_trigs), .chan_done(chan_done),
        .c0_tvalid(ch_valid[0]), .c0_tlast(ch_last[0]), .c0_tdata(ch_data[0]),
        .c0_tready(c0_tready),
        .c1_tvalid(ch_valid[1]), .c1_tlast(ch_last[1]), .c1_tdata(ch_data[1]),
        .c1_tready(c1_tready),
        .daq_valid(daq_valid), .daq_header(daq_header), .daq_trailer(daq_trailer),
        .daq_data(daq_data), .daq_ready(daq_ready)
    );

    always #(PERIOD_NS / 2) clk125 = ~clk125;

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic note_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic report_test(input int num, input string name, input int base_err);
        n_tests++;
        if (err_cnt == base_err) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, err_cnt - base_err);
            n_bad++;
        end
    endtask

    // hold trigger until the go pulse shows, a busy manager just ignores it
    task automatic start_fill();
        trigger <= 1'b1;
        do @(posedge clk125); while (acq_trigs !== {NCH{1'b1}});
        trigger <= 1'b0;
        fills_started++;
    endtask

    task automatic wait_events();
        while (events_done < fills_started) @(posedge clk125);
    endtask

    task automatic run_fill();
        start_fill();
        wait_events();
    endtask

    // channel models, daq ready and the reference model
    always @(posedge clk125) begin
        exp_word_t w;
        if (!rst) begin
            daq_ready <= (($urandom % 100) >= stall_pct);
            if (acq_trigs != '0) begin
                check_val("acq_trigs", acq_trigs, {NCH{1'b1}});  // both bits together
                if (acq_prev)
                    note_error("acq_trigs stayed high for two cycles");
                model_fill = model_fill + 1'b1;
                exp_fill.push_back(model_fill);
                acq_pulses <= acq_pulses + 1;
            end
            acq_prev = |acq_trigs;
            for (int c = 0; c < NCH; c++) begin
                if (acq_trigs[c]) begin
                    pkt_len[c] = 1 + ($urandom % MAX_WORDS);  // 1 to 8 words
                    pkt_pos[c] = 0;
                    chan_done[c] <= 1'b0;
                    for (int k = 0; k < pkt_len[c]; k++) begin
                        pkt[c][k] = $urandom;
                        w.last = (k == pkt_len[c] - 1);
                        w.fill = model_fill;
                        w.data = pkt[c][k];
                        if (c == 0)
                            exp_c0.push_back(w);
                        else
                            exp_c1.push_back(w);
                    end
                end else if (ch_valid[c] && ch_ready[c]) begin
                    pkt_pos[c] = pkt_pos[c] + 1;  // word taken this edge
                end
                // a stalled word stays put, otherwise maybe leave a gap
                if (!(ch_valid[c] && !ch_ready[c])) begin
                    if (pkt_pos[c] < pkt_len[c] && ($urandom % 4) != 0) begin
                        ch_valid[c] <= 1'b1;
                        ch_data[c]  <= pkt[c][pkt_pos[c]];
                        ch_last[c]  <= (pkt_pos[c] == pkt_len[c] - 1);
                    end else begin
                        ch_valid[c] <= 1'b0;
                    end
                end
                if (pkt_len[c] != 0 && pkt_pos[c] == pkt_len[c])
                    chan_done[c] <= 1'b1;  // up until the next go
            end
        end
    end

    // daq sink, checks every accepted word against the model
    always @(posedge clk125) begin
        exp_word_t  w;
        fill_num_t  f;
        logic [7:0] tag;
        logic [7:0] exp_tag;
        if (!rst && daq_valid && daq_ready) begin
            tag = daq_data[63:56];
            if (daq_header) begin
                if (in_event)
                    note_error("header arrived inside an open event");
                f = '0;
                if (exp_fill.size() == 0)
                    note_error("header arrived with no fill started");
                else
                    f = exp_fill.pop_front();
                check_val("daq_data", daq_data, {`WFD_HEADER_MARK, f, 32'd0});
                check_val("header fill", daq_data[55:32], hdr_next);  // 1, 2, 3 with no gap
                hdr_next = hdr_next + 1'b1;
                cur_fill = f;
                cur_cnt  = 0;
                in_event = 1'b1;
                pkt_open = 1'b0;
            end else if (daq_trailer) begin
                if (pkt_open)
                    note_error("trailer arrived before a packet ended");
                check_val("daq_data", daq_data, {`WFD_TRAILER_MARK, cur_fill, 32'(cur_cnt)});
                in_event = 1'b0;
                events_done <= events_done + 1;
            end else begin
                if (!in_event)
                    note_error("payload word arrived outside an event");
                if (pkt_open && tag != open_chan)
                    note_error("packets of two channels interleaved");
                w       = '0;
                exp_tag = 8'hFF;  // no channel matched
                if (tag == 8'd0 && exp_c0.size() > 0) begin
                    w       = exp_c0.pop_front();
                    exp_tag = 8'd0;
                end else if (tag == 8'd1 && exp_c1.size() > 0) begin
                    w       = exp_c1.pop_front();
                    exp_tag = 8'd1;
                end else begin
                    note_error("payload word with no expected word for its channel tag");
                end
                check_val("daq_data", daq_data, {exp_tag, w.fill, w.data});
                pkt_open  = !w.last;
                open_chan = tag;
                cur_cnt++;
            end
        end
    end

    initial begin
        int base_err;
        void'($urandom(32'h449f_0511));
        repeat (4) @(posedge clk125);
        rst <= 1'b0;

        base_err = err_cnt;
        repeat (4) begin
            @(posedge clk125);
            check_val("daq_valid", daq_valid, 0);
            check_val("acq_trigs", acq_trigs, 0);
            check_val("c0_tready", c0_tready, 0);
            check_val("c1_tready", c1_tready, 0);
        end
        report_test(1, "idle after reset", base_err);

        base_err  = err_cnt;
        stall_pct <= 20;
        run_fill();
        check_val("acq pulses", acq_pulses, 1);
        check_val("events", events_done, 1);
        report_test(2, "single fill", base_err);

        // extra triggers only while some channel is still sending
        base_err = err_cnt;
        start_fill();
        repeat (6) begin
            @(posedge clk125);
            if (chan_done != {NCH{1'b1}}) begin
                trigger <= 1'b1;
                @(posedge clk125);
                trigger <= 1'b0;
            end
        end
        wait_events();
        repeat (10) @(posedge clk125);  // room for a stray go pulse
        check_val("acq pulses", acq_pulses, fills_started);
        check_val("events", events_done, fills_started);
        report_test(3, "triggers during a fill", base_err);

        base_err = err_cnt;
        repeat (20) run_fill();
        check_val("next header fill", hdr_next, fills_started + 1);
        report_test(4, "twenty fills in sequence", base_err);

        base_err  = err_cnt;
        stall_pct <= 60;  // heavy daq back-pressure
        repeat (10) run_fill();
        repeat (5) @(posedge clk125);
        check_val("words left channel 0", exp_c0.size(), 0);
        check_val("words left channel 1", exp_c1.size(), 0);
        check_val("fills left", exp_fill.size(), 0);
        check_val("events", events_done, acq_pulses);
        report_test(5, "back-pressure", base_err);

        $display("summary: %0d tests run, %0d with errors, %0d mismatches",
                 n_tests, n_bad, err_cnt);
        if (err_cnt == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // bound on the whole run, from fill count, packet length and stalls
    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns with %0d of %0d fills framed",
                 WATCHDOG_NS, events_done, TOTAL_FILLS);
        $display("tests failed");
        $finish;
    end

endmodule

/* trigger_manager.sv */
// trigger manager, sends go to the channels, numbers each fill and waits for channel done
`timescale 1ns/1ps
`include "wfd_config.svh"

module trigger_manager import wfd_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     trigger,     // acquisition trigger pulse
    input  logic                     busy,        // event builder still framing a fill
    input  logic [`WFD_NUM_CHAN-1:0] chan_done,   // level per channel
    output logic [`WFD_NUM_CHAN-1:0] acq_trigs,   // go pulse to every channel
    output logic                     fill_valid,  // push into fill fifo
    output fill_num_t                fill_num,
    input  logic                     fill_ready
);

    logic                     waiting;    // fill in progress
    logic [`WFD_NUM_CHAN-1:0] done_seen;  // sticky done within the fill
    fill_num_t                fill_cnt;   // number for the next fill
    logic                     accept;
    logic                     all_done;

    assign accept = trigger && !waiting && !busy && fill_ready;

    // done from the previous fill is still up while go is out, skip that cycle
    assign all_done = waiting && !(|acq_trigs) && (&(done_seen | chan_done));

    always_ff @(posedge clk) begin
        if (rst) begin
            waiting    <= 1'b0;
            done_seen  <= '0;
            acq_trigs  <= '0;
            fill_valid <= 1'b0;
            fill_cnt   <= fill_num_t'(1);  // first fill is number 1
        end else begin
            acq_trigs  <= {`WFD_NUM_CHAN{accept}};  // one cycle go
            fill_valid <= accept;                   // push lands with go
            if (accept) begin
                waiting   <= 1'b1;
                done_seen <= '0;
                fill_cnt  <= fill_cnt + 1'b1;
            end else if (all_done) begin
                waiting <= 1'b0;                    // idle next cycle
            end else if (waiting && !(|acq_trigs)) begin
                done_seen <= done_seen | chan_done;
            end
        end
    end

    // number of the accepted fill, pushed together with go
    always_ff @(posedge clk) begin
        if (accept)
            fill_num <= fill_cnt;
    end

    // go must stay a single cycle pulse
    assert property (@(posedge clk) disable iff (rst)
        (|acq_trigs) |=> !(|acq_trigs));

endmodule

/* verilog.f */
+incdir+.
wfd_pkg.sv
chan_stream_if.sv
trigger_manager.sv
sync_fifo.sv
rx_switch.sv
event_builder.sv
wfd_top.sv
tb_wfd_top.sv

/* wfd_config.svh */
// wfd master configuration macros for widths, channel count, fifo depths and markers
`ifndef WFD_CONFIG_SVH
`define WFD_CONFIG_SVH

// number of channel fpgas, one serial link each
`define WFD_NUM_CHAN 2

// data path widths
`define WFD_FILL_W 24   // fill number
`define WFD_CHAN_W 32   // channel readout word
`define WFD_DAQ_W  64   // amc13 event data word

// buffering
`define WFD_FILL_FIFO_DEPTH 4   // fills queued between trigger and builder
`define WFD_DAQ_FIFO_DEPTH  8   // words ahead of the daq link

// event framing markers, top byte of header and trailer
`define WFD_HEADER_MARK  8'hA5
`define WFD_TRAILER_MARK 8'h5A

`endif

/* wfd_pkg.sv */
// wfd master shared types for fill numbers, channel words, daq words and builder states
`include "wfd_config.svh"

package wfd_pkg;

    // fill number handed from trigger manager to event builder
    typedef logic [`WFD_FILL_W-1:0] fill_num_t;

    // channel index, also carried as stream tid
    typedef logic [$clog2(`WFD_NUM_CHAN)-1:0] chan_id_t;

    // one word of a channel readout stream
    typedef logic [`WFD_CHAN_W-1:0] chan_data_t;

    // word toward the daq link, flags ride with the data
    typedef struct packed {
        logic                  header;   // first word of an event
        logic                  trailer;  // last word of an event
        logic [`WFD_DAQ_W-1:0] data;
    } daq_word_t;

    // event builder fsm
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,  // waiting for a fill number
        ST_HEADER  = 2'd1,  // header word out
        ST_PAYLOAD = 2'd2,  // channel words out
        ST_TRAILER = 2'd3   // trailer word out
    } builder_state_t;

endpackage

/* wfd_top.sv */
// wfd master acquisition path, trigger to event words for the amc13 daq link
`timescale 1ns/1ps
`include "wfd_config.svh"

module wfd_top import wfd_pkg::*; (
    input  logic                     clk125,
    input  logic                     rst,
    input  logic                     trigger,
    output logic [`WFD_NUM_CHAN-1:0] acq_trigs,   // go to channel fpgas
    input  logic [`WFD_NUM_CHAN-1:0] chan_done,
    input  logic                     c0_tvalid,   // channel 0 readout
    input  logic                     c0_tlast,
    input  chan_data_t               c0_tdata,
    output logic                     c0_tready,
    input  logic                     c1_tvalid,   // channel 1 readout
    input  logic                     c1_tlast,
    input  chan_data_t               c1_tdata,
    output logic                     c1_tready,
    output logic                     daq_valid,   // amc13 event data
    output logic                     daq_header,
    output logic                     daq_trailer,
    output logic [`WFD_DAQ_W-1:0]    daq_data,
    input  logic                     daq_ready
);

    logic      tm_fill_valid, tm_fill_ready;    // tm to fill fifo
    fill_num_t tm_fill_num;
    logic      eb_fill_valid, eb_fill_ready;    // fill fifo to builder
    fill_num_t eb_fill_num;
    logic      busy;
    logic      eb_daq_valid, eb_daq_ready;      // builder to daq fifo
    daq_word_t eb_daq_word;
    daq_word_t daq_word;

    chan_stream_if chan_s [`WFD_NUM_CHAN] ();   // channel inputs
    chan_stream_if merged_s ();                 // arbiter to builder

    assign chan_s[0].tvalid = c0_tvalid;
    assign chan_s[0].tlast  = c0_tlast;
    assign chan_s[0].tdata  = c0_tdata;
    assign chan_s[0].tid    = chan_id_t'(0);
    assign c0_tready        = chan_s[0].tready;
    assign chan_s[1].tvalid = c1_tvalid;
    assign chan_s[1].tlast  = c1_tlast;
    assign chan_s[1].tdata  = c1_tdata;
    assign chan_s[1].tid    = chan_id_t'(1);
    assign c1_tready        = chan_s[1].tready;

    trigger_manager tm_inst (
        .clk(clk125), .rst(rst), .trigger(trigger), .busy(busy),
        .chan_done(chan_done), .acq_trigs(acq_trigs),
        .fill_valid(tm_fill_valid), .fill_num(tm_fill_num), .fill_ready(tm_fill_ready)
    );

    sync_fifo #(.payload_t(fill_num_t), .DEPTH(`WFD_FILL_FIFO_DEPTH)) fill_fifo_inst (
        .clk(clk125), .rst(rst),
        .in_valid(tm_fill_valid), .in_data(tm_fill_num), .in_ready(tm_fill_ready),
        .out_valid(eb_fill_valid), .out_data(eb_fill_num), .out_ready(eb_fill_ready)
    );

    rx_switch rx_switch_inst (.clk(clk125), .rst(rst), .chan_in(chan_s), .merged(merged_s));

    event_builder eb_inst (
        .clk(clk125), .rst(rst),
        .fill_valid(eb_fill_valid), .fill_num(eb_fill_num), .fill_ready(eb_fill_ready),
        .merged(merged_s),
        .daq_out_valid(eb_daq_valid), .daq_out(eb_daq_word), .daq_out_ready(eb_daq_ready),
        .busy(busy)
    );

    sync_fifo #(.payload_t(daq_word_t), .DEPTH(`WFD_DAQ_FIFO_DEPTH)) daq_fifo_inst (
        .clk(clk125), .rst(rst),
        .in_valid(eb_daq_valid), .in_data(eb_daq_word), .in_ready(eb_daq_ready),
        .out_valid(daq_valid), .out_data(daq_word), .out_ready(daq_ready)
    );

    // split the daq word into link signals
    assign daq_header  = daq_word.header;
    assign daq_trailer = daq_word.trailer;
    assign daq_data    = daq_word.data;

endmodule
